//--- tb.f
+incdir+include
design/tlp_mon_pkg.sv
design/tlp_rec_if.sv
design/tlp_hdr_extract.sv
design/tlp_classify.sv
design/tlp_stats.sv
design/wb_csr.sv
design/pcie_tlp_monitor.sv
tb/tb_pcie_tlp_monitor.sv

//--- Makefile
# Verilator build and run of the PCIe TLP monitor testbench
VERILATOR ?= verilator
TOP       ?= tb_pcie_tlp_monitor
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator, run, and search $(LOG) for a failure"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_pcie_tlp_monitor.sv
////////////////////
// random TLP traffic on both streams, checked through wishbone reads against a model
////////////////////
`timescale 1ns/1ns
`include "tlp_mon_defs.svh"

module tb_pcie_tlp_monitor;
   import tlp_mon_pkg::*;

   localparam int timeout_cycles = 32;
   localparam int dw_n = `TLP_DATA_W / 32;

   logic                   clk;
   logic                   rstn;
   logic [`TLP_DATA_W-1:0] tx_st_data;
   logic [`TLP_LANES-1:0]  tx_st_valid;
   logic [`TLP_LANES-1:0]  tx_st_sop;
   logic [`TLP_LANES-1:0]  tx_st_eop;
   logic                   tx_st_ready;
   logic [`TLP_DATA_W-1:0] rx_st_data;
   logic [`TLP_LANES-1:0]  rx_st_valid;
   logic [`TLP_LANES-1:0]  rx_st_sop;
   logic [`TLP_LANES-1:0]  rx_st_eop;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [`WB_ADR_W-1:0]   wb_adr;
   logic [`WB_DAT_W-1:0]   wb_dat_w;
   logic [`WB_DAT_W-1:0]   wb_dat_r;
   logic                   wb_ack;

   // model state
   logic [`TLP_CNT_W-1:0] exp_cnt [2][`TLP_CATS];
   logic [`TLP_CNT_W-1:0] exp_total [2];
   tlp_hdr_t              exp_hdr [2];
   logic [`WB_DAT_W-1:0]  exp_tag_len [2];
   logic [7:0]            fmt_types [20];
   integer                seed;

   pcie_tlp_monitor dut_i (.*);

   always #4 clk = ~clk;

   ////////////////////
   // reference rules
   ////////////////////

   function automatic tlp_cat_e expected_cat(input logic [7:0] ft);
      case (ft)
         8'h00, 8'h20:               return cat_mrd;
         8'h01, 8'h21:               return cat_mrdlk;
         8'h40, 8'h60:               return cat_mwr;
         8'h02, 8'h42:               return cat_io;
         8'h04, 8'h44, 8'h05, 8'h45: return cat_cfg;
         8'h0A, 8'h4A, 8'h0B, 8'h4B: return cat_cpl;
         default: return (ft inside {[8'h30:8'h37], [8'h70:8'h77]}) ? cat_msg : cat_unknown;
      endcase
   endfunction

   function automatic logic [7:0] expected_tag(input tlp_hdr_t h);
      case (expected_cat(h.h1[31:24]))
         cat_cpl:                              return h.h3[15:8];
         cat_mrd, cat_mrdlk, cat_io, cat_cfg: return h.h2[15:8];
         default:                              return 8'h00;
      endcase
   endfunction

   task automatic model_count(input int dir, input tlp_hdr_t h);
      tlp_cat_e c;
      c = expected_cat(h.h1[31:24]);
      if (exp_cnt[dir][c] != '1) exp_cnt[dir][c] = exp_cnt[dir][c] + 1'b1;
      if (exp_total[dir] != '1) exp_total[dir] = exp_total[dir] + 1'b1;
      exp_hdr[dir] = h;
      // length field counts dwords, four bytes each
      exp_tag_len[dir] = {12'h000, expected_tag(h), 12'(h.h1[9:0] * 4)};
   endtask

   task automatic model_clear();
      for (int d = 0; d < 2; d++) begin
         for (int c = 0; c < `TLP_CATS; c++) exp_cnt[d][c] = '0;
         exp_total[d] = '0;
         exp_hdr[d] = '0;
         exp_tag_len[d] = '0;
      end
   endtask

   ////////////////////
   // checks
   ////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_count(input string test, input logic [`TLP_CNT_W-1:0] exp,
                              input logic [`TLP_CNT_W-1:0] act);
      if (act !== exp) abort_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
   endtask

   task automatic check_hdr(input string test, input tlp_hdr_t exp, input tlp_hdr_t act);
      if (act !== exp) abort_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
   endtask

   task automatic check_rec(input string test, input logic [`WB_DAT_W-1:0] exp,
                            input logic [`WB_DAT_W-1:0] act);
      if (act !== exp) abort_run($sformatf("Fail %s expected %h actual %h", test, exp, act));
   endtask

   ////////////////////
   // stimulus
   ////////////////////

   task automatic pick_ft(output logic [7:0] ft);
      int          idx;
      logic [31:0] r;
      idx = $unsigned($random(seed)) % 20;
      r = $random(seed);
      ft = fmt_types[idx];
      // message types spread over the routing field
      if (ft[3:0] == 4'h0 && ft[5:4] == 2'b11) ft[2:0] = r[2:0];
   endtask

   task automatic make_hdr(input logic [7:0] ft, output tlp_hdr_t h);
      h.h1 = $random(seed);
      h.h2 = $random(seed);
      h.h3 = $random(seed);
      h.h1[31:24] = ft;
   endtask

   task automatic random_data(output logic [`TLP_DATA_W-1:0] d);
      for (int i = 0; i < dw_n; i++) d[32*i +: 32] = $random(seed);
   endtask

   // k counts dwords in wire order, RX puts dword 0 at the top
   function automatic logic [`TLP_DATA_W-1:0] put_dw(input logic [`TLP_DATA_W-1:0] data,
                                                     input bit rev, input int k,
                                                     input logic [31:0] v);
      if (rev) data[32*(dw_n-1-k) +: 32] = v;
      else data[32*k +: 32] = v;
      return data;
   endfunction

   task automatic drive_beat(input int dir, input logic [`TLP_DATA_W-1:0] data,
                             input logic [3:0] valid, input logic [3:0] sop, input logic ready);
      @(posedge clk);
      #1;
      tx_st_data = data;
      rx_st_data = data;
      tx_st_valid = (dir == dir_tx) ? valid : 4'b0000;
      tx_st_sop = (dir == dir_tx) ? sop : 4'b0000;
      tx_st_ready = ready;
      rx_st_valid = (dir == dir_rx) ? valid : 4'b0000;
      rx_st_sop = (dir == dir_rx) ? sop : 4'b0000;
   endtask

   task automatic idle_beat();
      drive_beat(dir_tx, '0, 4'b0000, 4'b0000, 1'b1);
   endtask

   task automatic settle();
      repeat (6) idle_beat();
   endtask

   // beat that carries a header but must not be accepted
   task automatic drop_beat(input int dir);
      logic [`TLP_DATA_W-1:0] d;
      random_data(d);
      if (dir == dir_tx) drive_beat(dir, d, 4'b1111, 4'b0001, 1'b0);
      else drive_beat(dir, d, 4'b1110, 4'b1000, 1'b1);
   endtask

   // w is the start position in wire order, 3 splits over two beats
   task automatic send_tlp(input int dir, input int w, input tlp_hdr_t h, input int gap);
      logic [`TLP_DATA_W-1:0] d;
      logic [3:0]             sop;
      logic [3:0]             vld;
      bit                     rev;
      rev = (dir == dir_rx);
      random_data(d);
      d = put_dw(d, rev, 2*w, h.h1);
      d = put_dw(d, rev, 2*w+1, h.h2);
      if (w < 3) d = put_dw(d, rev, 2*w+2, h.h3);
      sop = 4'b0001 << (rev ? 3 - w : w);
      // TX valid covers only the lanes from the start onward
      vld = rev ? 4'b1111 : 4'b1111 << w;
      drive_beat(dir, d, vld, sop, 1'b1);
      if (w == 3) begin
         repeat (gap) idle_beat();
         random_data(d);
         d = put_dw(d, rev, 0, h.h3);
         drive_beat(dir, d, rev ? 4'b1111 : 4'b0001, 4'b0000, 1'b1);
      end
      model_count(dir, h);
   endtask

   ////////////////////
   // wishbone master
   ////////////////////

   task automatic bus_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
                             input logic [`WB_DAT_W-1:0] wdat, output logic [`WB_DAT_W-1:0] rdat);
      int n;
      @(posedge clk);
      #1;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we = we;
      wb_adr = adr;
      wb_dat_w = wdat;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
      end while (!wb_ack && n < timeout_cycles);
      if (!wb_ack) begin
         abort_run($sformatf("no wishbone ack within %0d cycles at address %h", n, adr));
      end else begin
         rdat = wb_dat_r;
         wb_cyc = 1'b0;
         wb_stb = 1'b0;
         wb_we = 1'b0;
      end
   endtask

   task automatic read_reg(input logic [`WB_ADR_W-1:0] adr, output logic [`WB_DAT_W-1:0] rdat);
      bus_access(1'b0, adr, '0, rdat);
   endtask

   task automatic clear_stats();
      logic [`WB_DAT_W-1:0] unused;
      bus_access(1'b1, `CSR_CLEAR, 32'h0, unused);
      model_clear();
   endtask

   // every counter, total, last header and tag/length word of both sides
   task automatic check_all(input string test);
      logic [`WB_DAT_W-1:0] r;
      tlp_hdr_t             h;
      for (int d = 0; d < 2; d++) begin
         for (int c = 0; c < `TLP_CATS; c++) begin
            read_reg(`WB_ADR_W'(`CSR_CNT_BASE + 8*d + c), r);
            check_count($sformatf("%s cnt[%0d][%0d]", test, d, c), exp_cnt[d][c],
                        r[`TLP_CNT_W-1:0]);
         end
         read_reg(`WB_ADR_W'(`CSR_TOTAL_BASE + d), r);
         check_count($sformatf("%s total[%0d]", test, d), exp_total[d], r[`TLP_CNT_W-1:0]);
         read_reg(`WB_ADR_W'(`CSR_HDR_BASE + 4*d), h.h1);
         read_reg(`WB_ADR_W'(`CSR_HDR_BASE + 4*d + 1), h.h2);
         read_reg(`WB_ADR_W'(`CSR_HDR_BASE + 4*d + 2), h.h3);
         check_hdr($sformatf("%s hdr[%0d]", test, d), exp_hdr[d], h);
         read_reg(`WB_ADR_W'(`CSR_HDR_BASE + 4*d + 3), r);
         check_rec($sformatf("%s tag_len[%0d]", test, d), exp_tag_len[d], r);
      end
   endtask

   ////////////////////
   // sequence
   ////////////////////

   initial begin
      logic [31:0]          r;
      logic [7:0]           ft;
      tlp_hdr_t             h;
      logic [`WB_DAT_W-1:0] rd;
      seed = 32'h4fe0e70e;
      clk = 1'b0;
      rstn = 1'b0;
      tx_st_data = '0;
      tx_st_valid = '0;
      tx_st_sop = '0;
      tx_st_eop = '0;
      tx_st_ready = 1'b0;
      rx_st_data = '0;
      rx_st_valid = '0;
      rx_st_sop = '0;
      rx_st_eop = '0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      fmt_types = '{8'h00, 8'h20, 8'h01, 8'h21, 8'h40, 8'h60, 8'h02, 8'h42, 8'h04, 8'h44,
                    8'h05, 8'h45, 8'h30, 8'h70, 8'h0A, 8'h4A, 8'h0B, 8'h4B, 8'h1F, 8'h83};
      model_clear();
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;

      // TX lanes 0..2, some beats with ready low
      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         if (r[1:0] == 2'b00) begin
            drop_beat(dir_tx);
         end else begin
            pick_ft(ft);
            make_hdr(ft, h);
            send_tlp(dir_tx, r[9:8] % 3, h, 0);
         end
      end
      settle();
      check_all("tx_random");

      // TX lane 3, tail a few idle cycles later
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         pick_ft(ft);
         make_hdr(ft, h);
         send_tlp(dir_tx, 3, h, r[2:0]);
      end
      settle();
      check_all("tx_split");

      // RX reversed, all positions, valid lane 0 low now and then
      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         if (r[1:0] == 2'b00) begin
            drop_beat(dir_rx);
         end else begin
            pick_ft(ft);
            make_hdr(ft, h);
            send_tlp(dir_rx, r[9:8], h, r[13:12]);
         end
      end
      settle();
      check_all("rx_random");

      // completion, memory read and posted write pick different tag sources
      for (int i = 0; i < 3; i++) begin
         ft = (i == 0) ? 8'h4A : (i == 1) ? 8'h20 : 8'h60;
         make_hdr(ft, h);
         send_tlp(dir_tx, 1, h, 0);
         settle();
         read_reg(`WB_ADR_W'(`CSR_HDR_BASE + 3), rd);
         check_rec($sformatf("tag_len ft %h", ft), exp_tag_len[dir_tx], rd);
      end

      clear_stats();
      check_all("clear");
      read_reg(6'h12, rd);
      check_rec("unmapped 12", 32'h0, rd);
      read_reg(`CSR_CLEAR, rd);
      check_rec("unmapped 20", 32'h0, rd);
      read_reg(6'h3F, rd);
      check_rec("unmapped 3f", 32'h0, rd);

      // overfill the MWr counter
      for (int i = 0; i < (1 << `TLP_CNT_W) + 3; i++) begin
         make_hdr(8'h40, h);
         send_tlp(dir_tx, 0, h, 0);
      end
      settle();
      read_reg(`WB_ADR_W'(`CSR_CNT_BASE + cat_mwr), rd);
      check_count("mwr_saturation", '1, rd[`TLP_CNT_W-1:0]);
      check_all("saturation");

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

//--- design/pcie_tlp_monitor.sv
////////////////////
// PCIe TLP monitor top, TX and RX extract/classify chains into statistics and a wishbone CSR
////////////////////
`timescale 1ns/1ns
`include "tlp_mon_defs.svh"

module pcie_tlp_monitor (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`TLP_DATA_W-1:0] tx_st_data,
   input  logic [`TLP_LANES-1:0]  tx_st_valid,
   input  logic [`TLP_LANES-1:0]  tx_st_sop,
   input  logic [`TLP_LANES-1:0]  tx_st_eop,
   input  logic                   tx_st_ready,
   input  logic [`TLP_DATA_W-1:0] rx_st_data,
   input  logic [`TLP_LANES-1:0]  rx_st_valid,
   input  logic [`TLP_LANES-1:0]  rx_st_sop,
   input  logic [`TLP_LANES-1:0]  rx_st_eop,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  logic [`WB_ADR_W-1:0]   wb_adr,
   input  logic [`WB_DAT_W-1:0]   wb_dat_w,
   output logic [`WB_DAT_W-1:0]   wb_dat_r,
   output logic                   wb_ack
);
   import tlp_mon_pkg::*;

   logic                                       tx_accept;
   logic                                       rx_accept;
   logic                                       tx_hdr_valid;
   logic                                       rx_hdr_valid;
   tlp_hdr_t                                   tx_hdr;
   tlp_hdr_t                                   rx_hdr;
   logic                                       clear;
   logic [1:0][`TLP_CATS-1:0][`TLP_CNT_W-1:0] cnt;
   logic [1:0][`TLP_CNT_W-1:0]                total;
   tlp_rec_t [1:0]                             last_rec;

   // TX needs ready, RX only looks at valid lane 0
   assign tx_accept = (|tx_st_valid) & tx_st_ready;
   assign rx_accept = rx_st_valid[0];

   tlp_rec_if tx_rec_if_i (.clk(clk), .rstn(rstn));
   tlp_rec_if rx_rec_if_i (.clk(clk), .rstn(rstn));

   ////////////////////
   // TX chain
   ////////////////////

   tlp_hdr_extract #(.lane_reversed(1'b0)) tx_extract_i (
      .clk(clk), .rstn(rstn), .data(tx_st_data), .sop(tx_st_sop), .accept(tx_accept),
      .hdr_valid(tx_hdr_valid), .hdr(tx_hdr));

   tlp_classify tx_classify_i (
      .clk(clk), .rstn(rstn), .hdr_valid(tx_hdr_valid), .hdr(tx_hdr), .rec(tx_rec_if_i.src));

   ////////////////////
   // RX chain
   ////////////////////

   tlp_hdr_extract #(.lane_reversed(1'b1)) rx_extract_i (
      .clk(clk), .rstn(rstn), .data(rx_st_data), .sop(rx_st_sop), .accept(rx_accept),
      .hdr_valid(rx_hdr_valid), .hdr(rx_hdr));

   tlp_classify rx_classify_i (
      .clk(clk), .rstn(rstn), .hdr_valid(rx_hdr_valid), .hdr(rx_hdr), .rec(rx_rec_if_i.src));

   tlp_stats stats_i (
      .clk(clk), .rstn(rstn), .tx_rec(tx_rec_if_i.dst), .rx_rec(rx_rec_if_i.dst),
      .clear(clear), .cnt(cnt), .total(total), .last_rec(last_rec));

   wb_csr csr_i (
      .clk(clk), .rstn(rstn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .cnt(cnt), .total(total),
      .last_rec(last_rec), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .clear(clear));

endmodule

//--- design/wb_csr.sv
////////////////////
// wishbone classic slave, reads counters and last headers, write to the clear address resets
////////////////////
`timescale 1ns/1ns
`include "tlp_mon_defs.svh"

module wb_csr (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic                                       wb_cyc,
   input  logic                                       wb_stb,
   input  logic                                       wb_we,
   input  logic [`WB_ADR_W-1:0]                       wb_adr,
   input  logic [`WB_DAT_W-1:0]                       wb_dat_w,
   input  logic [1:0][`TLP_CATS-1:0][`TLP_CNT_W-1:0] cnt,
   input  logic [1:0][`TLP_CNT_W-1:0]                total,
   input  tlp_mon_pkg::tlp_rec_t [1:0]               last_rec,
   output logic [`WB_DAT_W-1:0]                       wb_dat_r,
   output logic                                       wb_ack,
   output logic                                       clear
);
   import tlp_mon_pkg::*;

   logic                 req;
   logic [`WB_ADR_W-1:0] cnt_off;
   logic [`WB_ADR_W-1:0] tot_off;
   logic [`WB_ADR_W-1:0] hdr_off;
   tlp_rec_t             sel_rec;
   logic [`WB_DAT_W-1:0] rd_data;

   // new request, not the cycle that acks it
   assign req = wb_cyc & wb_stb & ~wb_ack;

   ////////////////////
   // read decode
   ////////////////////

   // offsets below a base wrap high and fall out of range
   always_comb begin
      cnt_off = wb_adr - `CSR_CNT_BASE;
      tot_off = wb_adr - `CSR_TOTAL_BASE;
      hdr_off = wb_adr - `CSR_HDR_BASE;
      sel_rec = last_rec[hdr_off[2]];
      rd_data = '0;
      if (cnt_off < 2 * `TLP_CATS) begin
         rd_data[`TLP_CNT_W-1:0] = cnt[cnt_off[3]][cnt_off[2:0]];
      end else if (tot_off < 2) begin
         rd_data[`TLP_CNT_W-1:0] = total[tot_off[0]];
      end else if (hdr_off < 8) begin
         case (hdr_off[1:0])
            2'd0:    rd_data = sel_rec.hdr.h1;
            2'd1:    rd_data = sel_rec.hdr.h2;
            2'd2:    rd_data = sel_rec.hdr.h3;
            default: rd_data = {12'h000, sel_rec.tag, sel_rec.len_bytes};
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wb_ack <= 1'b0;
         clear  <= 1'b0;
      end else begin
         wb_ack <= req;
         clear  <= req & wb_we & (wb_adr == `CSR_CLEAR);
      end
   end

   // read data lands with ack
   always_ff @(posedge clk) begin
      if (req) begin
         wb_dat_r <= rd_data;
      end
   end

   a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
      wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

//--- design/tlp_stats.sv
////////////////////
// saturating TLP counters per direction and category, plus the last record of each side
////////////////////
`timescale 1ns/1ns
`include "tlp_mon_defs.svh"

module tlp_stats (
   input  logic                                          clk,
   input  logic                                          rstn,
   tlp_rec_if.dst                                        tx_rec,
   tlp_rec_if.dst                                        rx_rec,
   input  logic                                          clear,
   output logic [1:0][`TLP_CATS-1:0][`TLP_CNT_W-1:0]    cnt,
   output logic [1:0][`TLP_CNT_W-1:0]                   total,
   output tlp_mon_pkg::tlp_rec_t [1:0]                  last_rec
);
   import tlp_mon_pkg::*;

   logic [1:0]     in_valid;
   tlp_rec_t [1:0] in_rec;

   function automatic logic [`TLP_CNT_W-1:0] sat_inc(input logic [`TLP_CNT_W-1:0] v);
      return (&v) ? v : v + 1'b1;
   endfunction

   // both directions through one update loop
   assign in_valid[dir_tx] = tx_rec.valid;
   assign in_valid[dir_rx] = rx_rec.valid;
   assign in_rec[dir_tx]   = tx_rec.rec;
   assign in_rec[dir_rx]   = rx_rec.rec;

   // clear wins over a record in the same cycle
   always_ff @(posedge clk) begin
      if (!rstn || clear) begin
         cnt      <= '0;
         total    <= '0;
         last_rec <= '0;
      end else begin
         for (int d = 0; d < 2; d++) begin
            if (in_valid[d]) begin
               cnt[d][in_rec[d].cat] <= sat_inc(cnt[d][in_rec[d].cat]);
               total[d]              <= sat_inc(total[d]);
               last_rec[d]           <= in_rec[d];
            end
         end
      end
   end

   ////////////////////
   // checks
   ////////////////////

   for (genvar d = 0; d < 2; d++) begin : g_dir
      for (genvar c = 0; c < `TLP_CATS; c++) begin : g_cat
         // a full counter stays full until cleared
         a_no_wrap: assert property (@(posedge clk) disable iff (!rstn)
            (&cnt[d][c]) && !clear |=> (&cnt[d][c]));
      end
   end

endmodule

//--- design/tlp_classify.sv
////////////////////
// fmt/type decode into category, tag and byte length, registered onto the record bus
////////////////////
`timescale 1ns/1ns

module tlp_classify (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  hdr_valid,
   input  tlp_mon_pkg::tlp_hdr_t hdr,
   tlp_rec_if.src                rec
);
   import tlp_mon_pkg::*;

   tlp_cat_e   cat;
   logic [7:0] tag;

   always_comb begin
      casez (hdr.h1[31:24])
         8'b00?0_0000: cat = cat_mrd;
         8'b00?0_0001: cat = cat_mrdlk;
         8'b01?0_0000: cat = cat_mwr;
         8'b0?00_0010: cat = cat_io;
         8'b0?00_010?: cat = cat_cfg;
         8'b0?11_0???: cat = cat_msg;
         8'b0?00_101?: cat = cat_cpl;
         default:      cat = cat_unknown;
      endcase
   end

   // completions carry the requester tag in h3, requests in h2
   always_comb begin
      case (cat)
         cat_cpl:                              tag = hdr.h3[15:8];
         cat_mrd, cat_mrdlk, cat_io, cat_cfg: tag = hdr.h2[15:8];
         default:                              tag = 8'h00;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rec.valid <= 1'b0;
      end else begin
         rec.valid <= hdr_valid;
      end
   end

   // length field in dwords, times four
   always_ff @(posedge clk) begin
      if (hdr_valid) begin
         rec.rec <= '{cat: cat, tag: tag, len_bytes: {hdr.h1[9:0], 2'b00}, hdr: hdr};
      end
   end

endmodule

//--- design/tlp_hdr_extract.sv
////////////////////
// pulls the 3-dword TLP header out of a 256-bit stream at the sop lane
// lane_reversed selects RX dword order, split headers finish on the next accepted beat
////////////////////
`timescale 1ns/1ns
`include "tlp_mon_defs.svh"

module tlp_hdr_extract #(
   parameter bit lane_reversed = 1'b0
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [`TLP_DATA_W-1:0] data,
   input  logic [`TLP_LANES-1:0]  sop,
   input  logic                   accept,
   output logic                   hdr_valid,
   output tlp_mon_pkg::tlp_hdr_t  hdr
);
   import tlp_mon_pkg::*;

   localparam int dw_n = `TLP_DATA_W / 32;
   localparam int last = `TLP_LANES - 1;

   logic [31:0]           dw [dw_n];
   logic [`TLP_LANES-1:0] sop_w;
   logic                  start_now;
   tlp_hdr_t              now_hdr;
   logic                  pend;
   logic [31:0]           pend_h1;
   logic [31:0]           pend_h2;

   ////////////////////
   // wire order
   ////////////////////

   // dw[0] and sop_w[0] are always the first on the wire
   always_comb begin
      for (int k = 0; k < dw_n; k++) begin
         dw[k] = lane_reversed ? data[32*(dw_n-1-k) +: 32] : data[32*k +: 32];
      end
      for (int i = 0; i < `TLP_LANES; i++) begin
         sop_w[i] = lane_reversed ? sop[last-i] : sop[i];
      end
   end

   // header that fits inside this beat
   always_comb begin
      start_now = 1'b0;
      now_hdr   = '0;
      for (int p = 0; p < last; p++) begin
         if (sop_w[p]) begin
            start_now  = 1'b1;
            now_hdr.h1 = dw[2*p];
            now_hdr.h2 = dw[2*p+1];
            now_hdr.h3 = dw[2*p+2];
         end
      end
   end

   ////////////////////
   // capture
   ////////////////////

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hdr_valid <= 1'b0;
         pend      <= 1'b0;
      end else begin
         hdr_valid <= accept & (pend | start_now);
         // start on the last lane waits for h3
         if (accept) begin
            pend <= sop_w[last];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && pend) begin
         hdr <= '{h1: pend_h1, h2: pend_h2, h3: dw[0]};
      end else if (accept && start_now) begin
         hdr <= now_hdr;
      end
      if (accept && sop_w[last]) begin
         pend_h1 <= dw[2*last];
         pend_h2 <= dw[2*last+1];
      end
   end

   // one start per beat, none next to the tail of a split header
   a_one_start: assert property (@(posedge clk) disable iff (!rstn)
      accept |-> $onehot0(sop) && !(pend && start_now));

endmodule

//--- design/tlp_rec_if.sv
////////////////////
// classified TLP record, one-cycle valid pulse, no back-pressure
////////////////////
`timescale 1ns/1ns

interface tlp_rec_if (
   input logic clk,
   input logic rstn
);
   import tlp_mon_pkg::*;

   logic     valid;
   tlp_rec_t rec;

   // classifier drives, statistics block observes
   modport src (input clk, input rstn, output valid, output rec);
   modport dst (input clk, input rstn, input valid, input rec);

endinterface

//--- design/tlp_mon_pkg.sv
////////////////////
// TLP category, header and record types used across the monitor
////////////////////
package tlp_mon_pkg;

   // direction index into the statistics arrays
   localparam int dir_tx = 0;
   localparam int dir_rx = 1;

   // category from the fmt/type byte of h1
   typedef enum logic [2:0] {
      cat_mrd     = 3'd0,
      cat_mrdlk   = 3'd1,
      cat_mwr     = 3'd2,
      cat_io      = 3'd3,
      cat_cfg     = 3'd4,
      cat_msg     = 3'd5,
      cat_cpl     = 3'd6,
      cat_unknown = 3'd7
   } tlp_cat_e;

   // first three header dwords, h1 first on the wire
   typedef struct packed {
      logic [31:0] h1;
      logic [31:0] h2;
      logic [31:0] h3;
   } tlp_hdr_t;

   // classified TLP
   // tag is zero for categories that carry none
   typedef struct packed {
      tlp_cat_e    cat;
      logic [7:0]  tag;
      logic [11:0] len_bytes;
      tlp_hdr_t    hdr;
   } tlp_rec_t;

endpackage

//--- include/tlp_mon_defs.svh
////////////////////
// widths and CSR map shared by the TLP monitor RTL, include where a macro is needed
////////////////////
`ifndef TLP_MON_DEFS_SVH
`define TLP_MON_DEFS_SVH

// streaming bus, 64-bit sop lanes
`define TLP_DATA_W     256
`define TLP_LANES      4
`define TLP_CATS       8

// statistics counters, saturate at all ones
`define TLP_CNT_W      16

// wishbone word address and data
`define WB_ADR_W       6
`define WB_DAT_W       32
`define CSR_CNT_BASE   6'h00
`define CSR_TOTAL_BASE 6'h10
`define CSR_HDR_BASE   6'h18
`define CSR_CLEAR      6'h20

`endif
